//--- filelist.f
hw/aznable_pkg.sv
hw/beam_timer.sv
hw/ms_timer.sv
hw/bus_control.sv
hw/input_ports.sv
hw/program_rom.sv
hw/work_ram.sv
hw/system_bus.sv
verification/tb_system_bus.sv

//--- hw/aznable_pkg.sv
package aznable_pkg;

	// memory widths, 32 KB program store and 16 KB work RAM
	parameter int PGROM_AW = 15;
	parameter int WKRAM_AW = 14;

	// program ROM sits below 0x8000, work RAM is 0xC000 and up
	parameter logic PGROM_A15 = 1'b0;
	parameter logic [1:0] WKRAM_PREFIX = 2'b11;

	// high address byte of each mapped input page
	parameter logic [7:0] PAGE_IN0 = 8'h80;
	parameter logic [7:0] PAGE_JOYSTICK = 8'h81;
	parameter logic [7:0] PAGE_ANALOG_L = 8'h82;
	parameter logic [7:0] PAGE_ANALOG_R = 8'h83;
	parameter logic [7:0] PAGE_PADDLE = 8'h84;
	parameter logic [7:0] PAGE_SPINNER = 8'h85;
	parameter logic [7:0] PAGE_PS2_KEY = 8'h86;
	parameter logic [7:0] PAGE_PS2_MOUSE = 8'h87;
	parameter logic [7:0] PAGE_TIMESTAMP = 8'h88;
	parameter logic [7:0] PAGE_TIMER = 8'h89;

	// pause trigger lives at 0x8A30..0x8A3F
	parameter logic [11:0] PAUSE_NIBBLE_ADDR = 12'h8A3;

	// download index that loads the program store
	parameter logic [7:0] DN_INDEX_PGROM = 8'd0;

	// low nibble of in0, debug bit (bit 0) is clear
	parameter logic [3:0] IN0_FIXED_BITS = 4'b1000;

	// cpu side, wr already inverted to active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data;
		logic wr;
	} cpu_bus_t;

	// host loader
	typedef struct packed {
		logic [16:0] addr;
		logic [7:0] data;
		logic [7:0] index;
		logic wr;
	} dn_port_t;

	typedef struct packed {
		logic [191:0] joystick;
		logic [95:0] analog_l;
		logic [95:0] analog_r;
		logic [47:0] paddle;
		logic [95:0] spinner;
		logic [10:0] ps2_key;
		logic [47:0] ps2_mouse;
		logic [32:0] timestamp;
	} input_bank_t;

	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic hs;
		logic vs;
		logic hblank;
		logic vblank;
	} beam_t;

	// one bit per bus target, all clear for unmapped space
	typedef enum logic [12:0] {
		REG_NONE = 13'd0,
		REG_PGROM = 13'd1,
		REG_WKRAM = 13'd2,
		REG_IN0 = 13'd4,
		REG_JOYSTICK = 13'd8,
		REG_ANALOG_L = 13'd16,
		REG_ANALOG_R = 13'd32,
		REG_PADDLE = 13'd64,
		REG_SPINNER = 13'd128,
		REG_PS2_KEY = 13'd256,
		REG_PS2_MOUSE = 13'd512,
		REG_TIMESTAMP = 13'd1024,
		REG_TIMER = 13'd2048,
		REG_PAUSE = 13'd4096
	} region_t;

endpackage

//--- hw/beam_timer.sv
`timescale 1ns/1ps

module beam_timer
	import aznable_pkg::*;
#(
	parameter int H_TOTAL = 396,
	parameter int H_ACTIVE = 320,
	parameter int HS_START = 336,
	parameter int HS_WIDTH = 32,
	parameter int V_TOTAL = 256,
	parameter int V_ACTIVE = 240,
	parameter int VS_START = 244,
	parameter int VS_WIDTH = 4
)
(
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	output beam_t beam
);

	localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

	logic [8:0] h_next;
	logic [8:0] v_next;

	// next pixel position, vcnt only moves on the line wrap
	always_comb
	begin
		h_next = beam.hcnt + 9'd1;
		v_next = beam.vcnt;
		if (beam.hcnt == H_LAST)
		begin
			h_next = 9'd0;
			v_next = (beam.vcnt == V_LAST) ? 9'd0 : beam.vcnt + 9'd1;
		end
	end

	// syncs and blanks come from the next position so they
	// land in the same register stage as the counters
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			beam <= '0;
		end
		else if (ce_6)
		begin
			beam.hcnt <= h_next;
			beam.vcnt <= v_next;
			beam.hblank <= (h_next >= H_ACTIVE);
			beam.vblank <= (v_next >= V_ACTIVE);
			beam.hs <= (h_next >= HS_START) && (h_next < HS_START + HS_WIDTH);
			beam.vs <= (v_next >= VS_START) && (v_next < VS_START + VS_WIDTH);
		end
	end

	// counters never leave the frame
	assert property (@(posedge clk_24) disable iff (reset)
		(beam.hcnt < H_TOTAL) && (beam.vcnt < V_TOTAL));

endmodule

//--- hw/bus_control.sv
`timescale 1ns/1ps

module bus_control
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic reset,
	input cpu_bus_t bus,
	input logic pause,
	input logic [7:0] pgrom_q,
	input logic [7:0] wkram_q,
	input logic [7:0] port_q,
	input logic [7:0] in0_q,
	input logic [15:0] timer_count,
	output region_t region,
	output logic timer_clear,
	output logic [7:0] cpu_din,
	output logic cpu_wait
);

	logic [7:0] page;
	logic pause_latch;

	assign page = bus.addr[15:8];

	// priority is ROM, then RAM, then the mapped pages
	always_comb
	begin
		region = REG_NONE;
		if (bus.addr[15] == PGROM_A15)
			region = REG_PGROM;
		else if (bus.addr[15:14] == WKRAM_PREFIX)
			region = REG_WKRAM;
		else if (bus.addr[15:4] == PAUSE_NIBBLE_ADDR)
			region = REG_PAUSE;
		else
		begin
			case (page)
				PAGE_IN0: region = REG_IN0;
				PAGE_JOYSTICK: region = REG_JOYSTICK;
				PAGE_ANALOG_L: region = REG_ANALOG_L;
				PAGE_ANALOG_R: region = REG_ANALOG_R;
				PAGE_PADDLE: region = REG_PADDLE;
				PAGE_SPINNER: region = REG_SPINNER;
				PAGE_PS2_KEY: region = REG_PS2_KEY;
				PAGE_PS2_MOUSE: region = REG_PS2_MOUSE;
				PAGE_TIMESTAMP: region = REG_TIMESTAMP;
				PAGE_TIMER: region = REG_TIMER;
				default: region = REG_NONE;
			endcase
		end
	end

	// any write into the timer page restarts the count
	assign timer_clear = bus.wr && (region == REG_TIMER);

	// host pause clears the latch and wins over a cpu set
	always_ff @(posedge clk_24)
	begin
		if (reset || pause)
			pause_latch <= 1'b0;
		else if (bus.wr && (region == REG_PAUSE))
			pause_latch <= 1'b1;
	end

	assign cpu_wait = pause || pause_latch;

	// memories are already registered and unmapped space reads zero
	always_comb
	begin
		case (region)
			REG_PGROM: cpu_din = pgrom_q;
			REG_WKRAM: cpu_din = wkram_q;
			REG_IN0: cpu_din = in0_q;
			REG_TIMER: cpu_din = bus.addr[0] ? timer_count[15:8] : timer_count[7:0];
			REG_JOYSTICK, REG_ANALOG_L, REG_ANALOG_R, REG_PADDLE, REG_SPINNER,
			REG_PS2_KEY, REG_PS2_MOUSE, REG_TIMESTAMP: cpu_din = port_q;
			default: cpu_din = 8'h00;
		endcase
	end

	assert property (@(posedge clk_24) $onehot0(region));

endmodule

//--- hw/input_ports.sv
`timescale 1ns/1ps

module input_ports
	import aznable_pkg::*;
(
	input input_bank_t inputs,
	input logic [4:0] addr,
	input region_t region,
	input beam_t beam,
	output logic [7:0] port_q,
	output logic [7:0] in0_q
);

	// byte idx of a source zero-extended to 32 bytes,
	// so bytes past the source width come back as zero
	function automatic logic [7:0] pick_byte(input logic [255:0] src, input logic [4:0] idx);
		return src[{idx, 3'b000} +: 8];
	endfunction

	// each source only sees as many address bits as it has bytes for
	always_comb
	begin
		case (region)
			REG_JOYSTICK:
				port_q = pick_byte(256'(inputs.joystick), addr);
			REG_ANALOG_L:
				port_q = pick_byte(256'(inputs.analog_l), {1'b0, addr[3:0]});
			REG_ANALOG_R:
				port_q = pick_byte(256'(inputs.analog_r), {1'b0, addr[3:0]});
			REG_SPINNER:
				port_q = pick_byte(256'(inputs.spinner), {1'b0, addr[3:0]});
			REG_PADDLE:
				port_q = pick_byte(256'(inputs.paddle), {2'b00, addr[2:0]});
			REG_PS2_MOUSE:
				port_q = pick_byte(256'(inputs.ps2_mouse), {2'b00, addr[2:0]});
			REG_TIMESTAMP:
				port_q = pick_byte(256'(inputs.timestamp), {2'b00, addr[2:0]});
			REG_PS2_KEY:
				port_q = pick_byte(256'(inputs.ps2_key), {4'b0000, addr[0]});
			default:
				port_q = 8'h00;
		endcase
	end

	// status byte, beam flags on top
	assign in0_q = {beam.hs, beam.vs, beam.hblank, beam.vblank, IN0_FIXED_BITS};

endmodule

//--- hw/ms_timer.sv
`timescale 1ns/1ps

module ms_timer #(
	parameter int TIMER_TICKS = 24000
)
(
	input logic clk_24,
	input logic reset,
	input logic clear,
	output logic [15:0] count
);

	localparam int PRE_W = $clog2(TIMER_TICKS);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TIMER_TICKS - 1);

	// clocks within the current millisecond
	logic [PRE_W-1:0] prescaler;

	always_ff @(posedge clk_24)
	begin
		if (reset || clear)
		begin
			prescaler <= '0;
			count <= 16'd0;
		end
		else if (prescaler == PRE_LAST)
		begin
			// one full millisecond, count wraps at 16 bits
			prescaler <= '0;
			count <= count + 16'd1;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
		end
	end

	assert property (@(posedge clk_24) disable iff (reset) prescaler < TIMER_TICKS);

endmodule

//--- hw/program_rom.sv
`timescale 1ns/1ps

module program_rom
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic [PGROM_AW-1:0] addr,
	input dn_port_t dn,
	output logic [7:0] q
);

	logic [7:0] mem [2**PGROM_AW];
	logic load_wr;

	// only index 0 belongs to this store
	assign load_wr = dn.wr && (dn.index == DN_INDEX_PGROM);

	// loader port
	always_ff @(posedge clk_24)
	begin
		if (load_wr)
			mem[dn.addr[PGROM_AW-1:0]] <= dn.data;
	end

	// cpu port, read only, one clock latency
	always_ff @(posedge clk_24)
	begin
		q <= mem[addr];
	end

	// a rom image larger than the store would wrap onto itself
	assert property (@(posedge clk_24) load_wr |-> (dn.addr < 2**PGROM_AW));

endmodule

//--- hw/system_bus.sv
`timescale 1ns/1ps

module system_bus
	import aznable_pkg::*;
#(
	parameter int H_TOTAL = 396,
	parameter int H_ACTIVE = 320,
	parameter int HS_START = 336,
	parameter int HS_WIDTH = 32,
	parameter int V_TOTAL = 256,
	parameter int V_ACTIVE = 240,
	parameter int VS_START = 244,
	parameter int VS_WIDTH = 4,
	parameter int TIMER_TICKS = 24000
)
(
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	input logic pause,
	input cpu_bus_t bus,
	input dn_port_t dn,
	input input_bank_t inputs,
	output logic [7:0] cpu_din,
	output logic cpu_wait,
	output beam_t beam
);

	region_t region;
	logic timer_clear;
	logic [15:0] timer_count;
	logic [7:0] pgrom_q;
	logic [7:0] wkram_q;
	logic [7:0] port_q;
	logic [7:0] in0_q;

	// video timing, also feeds the in0 status byte
	beam_timer #(
		.H_TOTAL(H_TOTAL),
		.H_ACTIVE(H_ACTIVE),
		.HS_START(HS_START),
		.HS_WIDTH(HS_WIDTH),
		.V_TOTAL(V_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.VS_START(VS_START),
		.VS_WIDTH(VS_WIDTH)
	) beam_timer_i (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.beam(beam)
	);

	ms_timer #(
		.TIMER_TICKS(TIMER_TICKS)
	) ms_timer_i (
		.clk_24(clk_24),
		.reset(reset),
		.clear(timer_clear),
		.count(timer_count)
	);

	bus_control bus_control_i (
		.clk_24(clk_24),
		.reset(reset),
		.bus(bus),
		.pause(pause),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q),
		.port_q(port_q),
		.in0_q(in0_q),
		.timer_count(timer_count),
		.region(region),
		.timer_clear(timer_clear),
		.cpu_din(cpu_din),
		.cpu_wait(cpu_wait)
	);

	input_ports input_ports_i (
		.inputs(inputs),
		.addr(bus.addr[4:0]),
		.region(region),
		.beam(beam),
		.port_q(port_q),
		.in0_q(in0_q)
	);

	program_rom program_rom_i (
		.clk_24(clk_24),
		.addr(bus.addr[PGROM_AW-1:0]),
		.dn(dn),
		.q(pgrom_q)
	);

	work_ram work_ram_i (
		.clk_24(clk_24),
		.bus(bus),
		.selected(region == REG_WKRAM),
		.q(wkram_q)
	);

endmodule

//--- hw/work_ram.sv
`timescale 1ns/1ps

module work_ram
	import aznable_pkg::*;
(
	input logic clk_24,
	input cpu_bus_t bus,
	input logic selected,
	output logic [7:0] q
);

	logic [7:0] mem [2**WKRAM_AW];
	logic [WKRAM_AW-1:0] index;

	// 0xC000..0xFFFF folds onto the low 14 bits
	assign index = bus.addr[WKRAM_AW-1:0];

	always_ff @(posedge clk_24)
	begin
		if (selected && bus.wr)
			mem[index] <= bus.data;
		// old contents on a write cycle
		q <= mem[index];
	end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_system_bus -f filelist.f
./obj_dir/Vtb_system_bus | tee sim.log
if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

//--- verification/tb_system_bus.sv
`timescale 1ns/1ps

module tb_system_bus
	import aznable_pkg::*;
();

	localparam int H_TOTAL = 396;
	localparam int H_ACTIVE = 320;
	localparam int HS_START = 336;
	localparam int HS_WIDTH = 32;
	localparam int V_TOTAL = 256;
	localparam int V_ACTIVE = 240;
	localparam int VS_START = 244;
	localparam int VS_WIDTH = 4;
	localparam int TICKS = 50;
	// one frame at one pixel per four clocks with some margin
	localparam int FRAME_LIMIT = 4 * H_TOTAL * V_TOTAL + 1000;

	logic clk_24;
	logic reset;
	logic ce_6 = 1'b0;
	logic pause;
	cpu_bus_t bus;
	dn_port_t dn;
	input_bank_t inputs;
	logic [7:0] cpu_din;
	logic cpu_wait;
	beam_t beam;

	int seed = 69653;
	int errors = 0;
	int timeouts = 0;
	logic [1:0] ce_phase = 2'd0;

	// expected read byte is only checked while chk_en is high
	logic chk_en;
	logic [7:0] exp_din;
	string chk_name;
	logic in0_en;
	logic wait_en;
	logic exp_wait;

	// reference beam position
	int m_hcnt;
	int m_vcnt;
	beam_t model_beam;

	logic [14:0] rom_addr [32];
	logic [7:0] rom_data [32];

	system_bus #(
		.H_TOTAL(H_TOTAL),
		.H_ACTIVE(H_ACTIVE),
		.HS_START(HS_START),
		.HS_WIDTH(HS_WIDTH),
		.V_TOTAL(V_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.VS_START(VS_START),
		.VS_WIDTH(VS_WIDTH),
		.TIMER_TICKS(TICKS)
	) dut_i (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.pause(pause),
		.bus(bus),
		.dn(dn),
		.inputs(inputs),
		.cpu_din(cpu_din),
		.cpu_wait(cpu_wait),
		.beam(beam)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #5 clk_24 = ~clk_24;
	end

	// pixel enable is high one clock in four
	always @(negedge clk_24)
	begin
		ce_phase <= ce_phase + 2'd1;
		ce_6 <= (ce_phase == 2'd3);
	end

	// counters step on ce_6 and vcnt steps on the line wrap
	always @(posedge clk_24)
	begin
		if (reset)
		begin
			m_hcnt <= 0;
			m_vcnt <= 0;
		end
		else if (ce_6)
		begin
			if (m_hcnt == H_TOTAL - 1)
			begin
				m_hcnt <= 0;
				m_vcnt <= (m_vcnt == V_TOTAL - 1) ? 0 : m_vcnt + 1;
			end
			else
				m_hcnt <= m_hcnt + 1;
		end
	end

	// syncs and blanks decoded from the model counters
	always_comb
	begin
		model_beam.hcnt = 9'(m_hcnt);
		model_beam.vcnt = 9'(m_vcnt);
		model_beam.hs = (m_hcnt >= HS_START) && (m_hcnt < HS_START + HS_WIDTH);
		model_beam.vs = (m_vcnt >= VS_START) && (m_vcnt < VS_START + VS_WIDTH);
		model_beam.hblank = (m_hcnt >= H_ACTIVE);
		model_beam.vblank = (m_vcnt >= V_ACTIVE);
	end

	assert property (@(posedge clk_24) chk_en |-> (cpu_din == exp_din))
	else
	begin
		errors++;
		$display("FAIL t=%0t cpu_din (%s) expected %02h actual %02h",
			$time, chk_name, exp_din, $sampled(cpu_din));
	end

	assert property (@(posedge clk_24) disable iff (reset) beam == model_beam)
	else
	begin
		errors++;
		$display("FAIL t=%0t beam expected %06h actual %06h",
			$time, $sampled(model_beam), $sampled(beam));
	end

	// in0 is hs, vs, hblank, vblank over the fixed nibble 1000
	assert property (@(posedge clk_24) in0_en |->
		(cpu_din == {model_beam.hs, model_beam.vs, model_beam.hblank,
		model_beam.vblank, 4'b1000}))
	else
	begin
		errors++;
		$display("FAIL t=%0t cpu_din (in0) expected %02h actual %02h", $time,
			{$sampled(model_beam.hs), $sampled(model_beam.vs),
			$sampled(model_beam.hblank), $sampled(model_beam.vblank), 4'b1000},
			$sampled(cpu_din));
	end

	assert property (@(posedge clk_24) wait_en |-> (cpu_wait == exp_wait))
	else
	begin
		errors++;
		$display("FAIL t=%0t cpu_wait expected %0b actual %0b",
			$time, exp_wait, $sampled(cpu_wait));
	end

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_24);
		chk_en = 1'b0;
		bus.addr = addr;
		bus.data = data;
		bus.wr = 1'b1;
		@(negedge clk_24);
		bus.wr = 1'b0;
	endtask

	task automatic dn_write(input logic [16:0] addr, input logic [7:0] data,
		input logic [7:0] index);
		@(negedge clk_24);
		dn.addr = addr;
		dn.data = data;
		dn.index = index;
		dn.wr = 1'b1;
		@(negedge clk_24);
		dn.wr = 1'b0;
	endtask

	// registered memories put the byte out one clock after the address
	task automatic read_mem(input logic [15:0] addr, input logic [7:0] want,
		input string name);
		@(negedge clk_24);
		chk_en = 1'b0;
		bus.addr = addr;
		@(negedge clk_24);
		exp_din = want;
		chk_name = name;
		chk_en = 1'b1;
	endtask

	// combinational sources are checked on the very next edge
	task automatic read_comb(input logic [15:0] addr, input logic [7:0] want,
		input string name);
		@(negedge clk_24);
		bus.addr = addr;
		exp_din = want;
		chk_name = name;
		chk_en = 1'b1;
	endtask

	task automatic stop_checks();
		@(negedge clk_24);
		chk_en = 1'b0;
	endtask

	task automatic randomize_inputs();
		logic [639:0] bits;
		int k;
		for (k = 0; k < 20; k++)
			bits[k * 32 +: 32] = $random(seed);
		@(negedge clk_24);
		chk_en = 1'b0;
		inputs = bits[619:0];
	endtask

	task automatic pause_step(input logic wr, input logic [15:0] addr, input logic p,
		input logic want);
		@(negedge clk_24);
		bus.wr = wr;
		bus.addr = addr;
		pause = p;
		exp_wait = want;
		wait_en = 1'b1;
	endtask

	// hcnt sits at 0 for four clocks, so a negedge poll cannot miss it
	task automatic wait_for_line(input int line, input string what);
		int n;
		n = 0;
		while (!(beam.vcnt == 9'(line) && beam.hcnt == 9'd0) && n < FRAME_LIMIT)
		begin
			@(negedge clk_24);
			n++;
		end
		if (!(beam.vcnt == 9'(line) && beam.hcnt == 9'd0))
		begin
			timeouts++;
			$display("timeout: beam never reached %s", what);
		end
	endtask

	// byte n of page pg where n comes from the source's low address bits
	function automatic logic [7:0] expected_port(input int pg, input int a);
		logic [191:0] src;
		int width;
		int abits;
		int n;
		int b;
		logic [7:0] r;
		src = '0;
		width = 0;
		abits = 0;
		case (pg)
			1:
			begin
				src = inputs.joystick;
				width = 192;
				abits = 5;
			end
			2:
			begin
				src = inputs.analog_l;
				width = 96;
				abits = 4;
			end
			3:
			begin
				src = inputs.analog_r;
				width = 96;
				abits = 4;
			end
			4:
			begin
				src = inputs.paddle;
				width = 48;
				abits = 3;
			end
			5:
			begin
				src = inputs.spinner;
				width = 96;
				abits = 4;
			end
			6:
			begin
				src = inputs.ps2_key;
				width = 11;
				abits = 1;
			end
			7:
			begin
				src = inputs.ps2_mouse;
				width = 48;
				abits = 3;
			end
			default:
			begin
				src = inputs.timestamp;
				width = 33;
				abits = 3;
			end
		endcase
		n = a % (1 << abits);
		r = 8'h00;
		// bits past the source width stay zero
		for (b = 0; b < 8; b++)
			if (n * 8 + b < width)
				r[b] = src[n * 8 + b];
		return r;
	endfunction

	initial
	begin
		int i;
		int pg;
		int a;
		logic [7:0] d;
		logic [15:0] ra;
		reset = 1'b1;
		pause = 1'b0;
		bus = '0;
		dn = '0;
		inputs = '0;
		chk_en = 1'b0;
		exp_din = 8'h00;
		chk_name = "";
		in0_en = 1'b0;
		wait_en = 1'b0;
		exp_wait = 1'b0;
		repeat (8) @(negedge clk_24);
		reset = 1'b0;

		// loader fills 32 spread addresses and index 3 must not land
		for (i = 0; i < 32; i++)
		begin
			rom_addr[i] = 15'(i * 1021 + 7);
			rom_data[i] = 8'($random(seed));
			dn_write(17'(rom_addr[i]), rom_data[i], 8'd0);
		end
		for (i = 0; i < 32; i += 4)
			dn_write(17'(rom_addr[i]), ~rom_data[i], 8'd3);
		for (i = 0; i < 32; i++)
			read_mem({1'b0, rom_addr[i]}, rom_data[i], "pgrom");
		// cpu has no write path into the program store
		cpu_write({1'b0, rom_addr[5]}, ~rom_data[5]);
		read_mem({1'b0, rom_addr[5]}, rom_data[5], "pgrom after cpu write");

		// work RAM covers both ends of the window first
		for (i = 0; i < 32; i++)
		begin
			ra = {2'b11, 14'($random(seed))};
			if (i == 0)
				ra = 16'hC000;
			if (i == 1)
				ra = 16'hFFFF;
			d = 8'($random(seed));
			cpu_write(ra, d);
			read_mem(ra, d, "wkram");
		end
		read_comb(16'h9000, 8'h00, "unmapped 9000");
		read_comb(16'hB000, 8'h00, "unmapped B000");

		// every byte index of pages 0x81..0x88
		for (i = 0; i < 2; i++)
		begin
			randomize_inputs();
			for (pg = 1; pg <= 8; pg++)
				for (a = 0; a < 32; a++)
					read_comb({8'h80 + 8'(pg), 3'b000, 5'(a)}, expected_port(pg, a),
						$sformatf("page %02h byte %0d", 8'h80 + pg, a));
		end
		stop_checks();

		// clear edge falls between the write and the negedge after it
		cpu_write(16'h8900, 8'h00);
		repeat (3 * TICKS) @(posedge clk_24);
		read_comb(16'h8900, 8'd3, "timer low at 3 ms");
		read_comb(16'h8901, 8'd0, "timer high at 3 ms");
		stop_checks();
		repeat (4 * TICKS - 2) @(posedge clk_24);
		read_comb(16'h8900, 8'd7, "timer low at 7 ms");
		read_comb(16'h8901, 8'd0, "timer high at 7 ms");
		stop_checks();

		// in0 checked against the beam model for one whole frame
		@(negedge clk_24);
		bus.addr = 16'h8000;
		in0_en = 1'b1;
		wait_for_line(0, "frame start");
		wait_for_line(V_TOTAL - 1, "last line");
		wait_for_line(0, "frame wrap");
		@(negedge clk_24);
		in0_en = 1'b0;

		// cpu set makes wait follow one cycle later and hold
		pause_step(1'b1, 16'h8A35, 1'b0, 1'b0);
		repeat (4) pause_step(1'b0, 16'h8A35, 1'b0, 1'b1);
		pause_step(1'b0, 16'h0000, 1'b1, 1'b1);
		repeat (3) pause_step(1'b0, 16'h0000, 1'b0, 1'b0);
		// host level on its own
		repeat (5) pause_step(1'b0, 16'h0000, 1'b1, 1'b1);
		repeat (3) pause_step(1'b0, 16'h0000, 1'b0, 1'b0);
		// clear wins over a set on the same edge
		pause_step(1'b1, 16'h8A3F, 1'b1, 1'b1);
		repeat (3) pause_step(1'b0, 16'h0000, 1'b0, 1'b0);
		@(negedge clk_24);
		wait_en = 1'b0;

		repeat (2) @(negedge clk_24);
		$display("errors: %0d timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
